// ==== verilog/lc4_pkg.sv ====
`default_nettype none

package lc4_pkg;

    // datapath words and register numbers
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;

    // condition bits, ordered negative, zero, positive
    typedef logic [2:0]  nzp_t;

    // trace stall code seen at writeback
    typedef logic [1:0]  stall_t;

    // operand bypass source for the execute stage
    typedef logic [1:0]  byp_t;

    localparam int N_REGS = 8;

    localparam stall_t STALL_NONE   = 2'd0;
    localparam stall_t STALL_BRANCH = 2'd2;
    localparam stall_t STALL_LOAD   = 2'd3;

    localparam byp_t BYP_NONE = 2'd0;
    localparam byp_t BYP_MEM  = 2'd1;
    localparam byp_t BYP_WB   = 2'd2;

    localparam word_t PC_RESET = 16'h8200;

    // all-zero word is a BR with no condition bits, so it never branches
    localparam word_t NOP_INSN = 16'h0000;

    // opcodes in bits 15:12
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // arithmetic sub-opcodes in bits 5:3, immediate form has bit 5 set
    localparam logic [2:0] SUB_ADD  = 3'b000;
    localparam logic [2:0] SUB_MUL  = 3'b001;
    localparam logic [2:0] SUB_SUB  = 3'b010;
    localparam logic [2:0] SUB_ADDI = 3'b1??;

    // logic sub-opcodes in bits 5:3
    localparam logic [2:0] SUB_AND  = 3'b000;
    localparam logic [2:0] SUB_NOT  = 3'b001;
    localparam logic [2:0] SUB_OR   = 3'b010;
    localparam logic [2:0] SUB_XOR  = 3'b011;
    localparam logic [2:0] SUB_ANDI = 3'b1??;

endpackage

`default_nettype wire

// ==== verilog/lc4_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder
    import lc4_pkg::*;
(
    input  word_t    i_insn,
    output reg_sel_t o_rs_sel,
    output reg_sel_t o_rt_sel,
    output reg_sel_t o_rd_sel,
    output logic     o_rs_re,
    output logic     o_rt_re,
    output logic     o_regfile_we,
    output logic     o_nzp_we,
    output logic     o_is_load,
    output logic     o_is_store,
    output logic     o_is_branch
);

    logic [3:0] opcode;
    logic [2:0] sub_op;

    assign opcode = i_insn[15:12];
    assign sub_op = i_insn[5:3];

    always_comb begin
        // field positions shared by most formats
        o_rs_sel     = i_insn[8:6];
        o_rt_sel     = i_insn[2:0];
        o_rd_sel     = i_insn[11:9];
        o_rs_re      = 1'b0;
        o_rt_re      = 1'b0;
        o_regfile_we = 1'b0;
        o_nzp_we     = 1'b0;
        o_is_load    = 1'b0;
        o_is_store   = 1'b0;
        o_is_branch  = 1'b0;

        case (opcode)
            OP_BR: begin
                // no condition bits means a NOP
                o_is_branch = (i_insn[11:9] != 3'b000);
            end
            OP_ARITH: begin
                casez (sub_op)
                    SUB_ADD, SUB_MUL, SUB_SUB: begin
                        o_rs_re      = 1'b1;
                        o_rt_re      = 1'b1;
                        o_regfile_we = 1'b1;
                        o_nzp_we     = 1'b1;
                    end
                    SUB_ADDI: begin
                        o_rs_re      = 1'b1;
                        o_regfile_we = 1'b1;
                        o_nzp_we     = 1'b1;
                    end
                    // divide is not implemented
                    default: ;
                endcase
            end
            OP_LOGIC: begin
                o_rs_re      = 1'b1;
                o_regfile_we = 1'b1;
                o_nzp_we     = 1'b1;
                casez (sub_op)
                    SUB_AND, SUB_OR, SUB_XOR: o_rt_re = 1'b1;
                    // NOT and the immediate form read rs only
                    default: o_rt_re = 1'b0;
                endcase
            end
            OP_LDR: begin
                o_rs_re      = 1'b1;
                o_regfile_we = 1'b1;
                o_nzp_we     = 1'b1;
                o_is_load    = 1'b1;
            end
            OP_STR: begin
                // store data register sits where a destination would
                o_rt_sel   = i_insn[11:9];
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
            end
            OP_CONST: begin
                o_regfile_we = 1'b1;
                o_nzp_we     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/lc4_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_rst,
    input  reg_sel_t i_rs_sel,
    input  reg_sel_t i_rt_sel,
    input  reg_sel_t i_rd_sel,
    input  word_t    i_wdata,
    input  logic     i_we,
    output word_t    o_rs_data,
    output word_t    o_rt_data
);

    word_t regs [N_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_we && (i_rd_sel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && (i_rd_sel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

// ==== verilog/lc4_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_alu
    import lc4_pkg::*;
(
    input  word_t i_insn,
    input  word_t i_pc,
    input  word_t i_rs_data,
    input  word_t i_rt_data,
    output word_t o_result
);

    logic [3:0] opcode;
    logic [2:0] sub_op;
    word_t      imm5;
    word_t      imm6;
    word_t      imm9;
    word_t      product;

    assign opcode = i_insn[15:12];
    assign sub_op = i_insn[5:3];

    // sign-extended immediates
    assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

    // low half of the product only
    assign product = i_rs_data * i_rt_data;

    always_comb begin
        o_result = '0;
        case (opcode)
            OP_ARITH: begin
                casez (sub_op)
                    SUB_ADD:  o_result = i_rs_data + i_rt_data;
                    SUB_MUL:  o_result = product;
                    SUB_SUB:  o_result = i_rs_data - i_rt_data;
                    SUB_ADDI: o_result = i_rs_data + imm5;
                    default:  o_result = '0;
                endcase
            end
            OP_LOGIC: begin
                casez (sub_op)
                    SUB_AND:  o_result = i_rs_data & i_rt_data;
                    SUB_NOT:  o_result = ~i_rs_data;
                    SUB_OR:   o_result = i_rs_data | i_rt_data;
                    SUB_XOR:  o_result = i_rs_data ^ i_rt_data;
                    SUB_ANDI: o_result = i_rs_data & imm5;
                    default:  o_result = '0;
                endcase
            end
            // base plus offset for both memory forms
            OP_LDR, OP_STR: o_result = i_rs_data + imm6;
            OP_CONST: o_result = imm9;
            // branch target, relative to the next PC
            OP_BR: o_result = i_pc + 16'd1 + imm9;
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/lc4_hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_unit
    import lc4_pkg::*;
(
    input  reg_sel_t i_d_rs_sel,
    input  reg_sel_t i_d_rt_sel,
    input  logic     i_d_rs_re,
    input  logic     i_d_rt_re,
    input  logic     i_d_is_store,
    input  reg_sel_t i_x_rs_sel,
    input  reg_sel_t i_x_rt_sel,
    input  reg_sel_t i_x_rd_sel,
    input  logic     i_x_rs_re,
    input  logic     i_x_rt_re,
    input  logic     i_x_is_load,
    input  logic     i_x_is_branch,
    input  reg_sel_t i_m_rd_sel,
    input  reg_sel_t i_m_rt_sel,
    input  logic     i_m_regfile_we,
    input  logic     i_m_is_load,
    input  logic     i_m_is_store,
    input  reg_sel_t i_w_rd_sel,
    input  logic     i_w_regfile_we,
    input  logic     i_branch_taken,
    output logic     o_stall_load,
    output logic     o_flush,
    output byp_t     o_rs_byp,
    output byp_t     o_rt_byp,
    output logic     o_store_byp
);

    logic rs_dep;
    logic rt_dep;
    logic m_fwd;

    // store data from a load is picked up later by the WM path
    assign rs_dep = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);
    assign rt_dep = i_d_rt_re && !i_d_is_store && (i_d_rt_sel == i_x_rd_sel);

    assign o_stall_load = i_x_is_load && (rs_dep || rt_dep);

    assign o_flush = i_x_is_branch && i_branch_taken;

    // a load in memory holds an address, not data, so it never feeds MX
    assign m_fwd = i_m_regfile_we && !i_m_is_load;

    always_comb begin
        o_rs_byp = BYP_NONE;
        if (i_x_rs_re && m_fwd && (i_x_rs_sel == i_m_rd_sel)) begin
            o_rs_byp = BYP_MEM;
        end else if (i_x_rs_re && i_w_regfile_we && (i_x_rs_sel == i_w_rd_sel)) begin
            o_rs_byp = BYP_WB;
        end
    end

    always_comb begin
        o_rt_byp = BYP_NONE;
        if (i_x_rt_re && m_fwd && (i_x_rt_sel == i_m_rd_sel)) begin
            o_rt_byp = BYP_MEM;
        end else if (i_x_rt_re && i_w_regfile_we && (i_x_rt_sel == i_w_rd_sel)) begin
            o_rt_byp = BYP_WB;
        end
    end

    assign o_store_byp = i_m_is_store && i_w_regfile_we && (i_m_rt_sel == i_w_rd_sel);

endmodule

`default_nettype wire

// ==== verilog/lc4_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_processor
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_rst,
    output word_t    o_cur_pc,
    input  word_t    i_cur_insn,
    output word_t    o_dmem_addr,
    output logic     o_dmem_we,
    output word_t    o_dmem_towrite,
    input  word_t    i_cur_dmem_data,
    output stall_t   o_test_stall,
    output word_t    o_test_cur_pc,
    output word_t    o_test_cur_insn,
    output word_t    o_test_regfile_data,
    output logic     o_test_regfile_we,
    output reg_sel_t o_test_regfile_wsel,
    output logic     o_test_nzp_we,
    output nzp_t     o_test_nzp_new_bits
);

    function automatic nzp_t sign_bits(input word_t value);
        if (value == '0) begin
            return 3'b010;
        end else if (value[15]) begin
            return 3'b100;
        end
        return 3'b001;
    endfunction

    word_t    f_pc, next_pc;
    word_t    d_insn, d_pc;
    stall_t   d_stall;
    word_t    x_insn, x_pc, x_rs_data, x_rt_data, x_rs_val, x_rt_val;
    stall_t   x_stall;
    word_t    m_insn, m_pc, m_result, m_store_data;
    stall_t   m_stall;
    nzp_t     m_nzp;
    reg_sel_t m_rd_sel, m_rt_sel;
    logic     m_regfile_we, m_nzp_we, m_is_load, m_is_store;
    word_t    w_insn, w_pc, w_result, w_load_data, wb_data;
    stall_t   w_stall;
    nzp_t     w_nzp;
    reg_sel_t w_rd_sel;
    logic     w_regfile_we, w_nzp_we, w_is_load;
    nzp_t     nzp_reg, nzp_eff, alu_nzp, load_nzp;
    reg_sel_t d_rs_sel, d_rt_sel;
    logic     d_rs_re, d_rt_re, d_is_store;
    reg_sel_t x_rs_sel, x_rt_sel, x_rd_sel;
    logic     x_rs_re, x_rt_re, x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
    word_t    rf_rs_data, rf_rt_data, alu_result;
    logic     stall_load, flush, branch_taken, store_byp;
    byp_t     rs_byp, rt_byp;

    lc4_decoder u_dec_d (
        .i_insn(d_insn), .o_rs_sel(d_rs_sel), .o_rt_sel(d_rt_sel), .o_rd_sel(),
        .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_regfile_we(), .o_nzp_we(),
        .o_is_load(), .o_is_store(d_is_store), .o_is_branch()
    );

    lc4_decoder u_dec_x (
        .i_insn(x_insn), .o_rs_sel(x_rs_sel), .o_rt_sel(x_rt_sel), .o_rd_sel(x_rd_sel),
        .o_rs_re(x_rs_re), .o_rt_re(x_rt_re), .o_regfile_we(x_regfile_we),
        .o_nzp_we(x_nzp_we), .o_is_load(x_is_load), .o_is_store(x_is_store),
        .o_is_branch(x_is_branch)
    );

    lc4_regfile u_regfile (
        .gwe(gwe), .i_rst(i_rst), .i_rs_sel(d_rs_sel), .i_rt_sel(d_rt_sel),
        .i_rd_sel(w_rd_sel), .i_wdata(wb_data), .i_we(w_regfile_we),
        .o_rs_data(rf_rs_data), .o_rt_data(rf_rt_data)
    );

    lc4_alu u_alu (
        .i_insn(x_insn), .i_pc(x_pc), .i_rs_data(x_rs_val), .i_rt_data(x_rt_val),
        .o_result(alu_result)
    );

    lc4_hazard_unit u_hazard (
        .i_d_rs_sel(d_rs_sel), .i_d_rt_sel(d_rt_sel), .i_d_rs_re(d_rs_re),
        .i_d_rt_re(d_rt_re), .i_d_is_store(d_is_store),
        .i_x_rs_sel(x_rs_sel), .i_x_rt_sel(x_rt_sel), .i_x_rd_sel(x_rd_sel),
        .i_x_rs_re(x_rs_re), .i_x_rt_re(x_rt_re), .i_x_is_load(x_is_load),
        .i_x_is_branch(x_is_branch),
        .i_m_rd_sel(m_rd_sel), .i_m_rt_sel(m_rt_sel), .i_m_regfile_we(m_regfile_we),
        .i_m_is_load(m_is_load), .i_m_is_store(m_is_store),
        .i_w_rd_sel(w_rd_sel), .i_w_regfile_we(w_regfile_we),
        .i_branch_taken(branch_taken),
        .o_stall_load(stall_load), .o_flush(flush), .o_rs_byp(rs_byp),
        .o_rt_byp(rt_byp), .o_store_byp(store_byp)
    );

    // fetch and decode hold together on a load-to-use stall
    assign next_pc = flush ? alu_result : f_pc + 16'd1;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            f_pc    <= PC_RESET;
            d_insn  <= NOP_INSN;
            d_stall <= STALL_BRANCH;
        end else if (!stall_load) begin
            f_pc    <= next_pc;
            d_insn  <= flush ? NOP_INSN : i_cur_insn;
            d_stall <= flush ? STALL_BRANCH : STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!stall_load) begin
            d_pc <= f_pc;
        end
    end

    // execute takes a bubble on flush or stall
    always_ff @(posedge gwe) begin
        if (i_rst || flush) begin
            x_insn  <= NOP_INSN;
            x_stall <= STALL_BRANCH;
        end else if (stall_load) begin
            x_insn  <= NOP_INSN;
            x_stall <= STALL_LOAD;
        end else begin
            x_insn  <= d_insn;
            x_stall <= d_stall;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc      <= d_pc;
        x_rs_data <= rf_rs_data;
        x_rt_data <= rf_rt_data;
    end

    // MX and WX operand bypass
    assign x_rs_val = (rs_byp == BYP_MEM) ? m_result :
                      (rs_byp == BYP_WB)  ? wb_data  : x_rs_data;
    assign x_rt_val = (rt_byp == BYP_MEM) ? m_result :
                      (rt_byp == BYP_WB)  ? wb_data  : x_rt_data;

    // a load in memory is the newest condition writer ahead of a branch
    assign alu_nzp      = sign_bits(alu_result);
    assign load_nzp     = sign_bits(i_cur_dmem_data);
    assign nzp_eff      = m_is_load ? load_nzp : nzp_reg;
    assign branch_taken = |(nzp_eff & x_insn[11:9]);

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_reg <= '0;
        end else if (x_nzp_we && !x_is_load) begin
            nzp_reg <= alu_nzp;
        end else if (m_is_load) begin
            nzp_reg <= load_nzp;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_insn       <= NOP_INSN;
            m_stall      <= STALL_BRANCH;
            m_regfile_we <= 1'b0;
            m_nzp_we     <= 1'b0;
            m_is_load    <= 1'b0;
            m_is_store   <= 1'b0;
        end else begin
            m_insn       <= x_insn;
            m_stall      <= x_stall;
            m_regfile_we <= x_regfile_we;
            m_nzp_we     <= x_nzp_we;
            m_is_load    <= x_is_load;
            m_is_store   <= x_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc         <= x_pc;
        m_result     <= alu_result;
        m_store_data <= x_rt_val;
        m_nzp        <= alu_nzp;
        m_rd_sel     <= x_rd_sel;
        m_rt_sel     <= x_rt_sel;
    end

    // data memory port, address comes from the execute result
    assign o_dmem_addr    = (m_is_load || m_is_store) ? m_result : '0;
    assign o_dmem_we      = m_is_store;
    assign o_dmem_towrite = store_byp ? wb_data : m_store_data;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            w_insn       <= NOP_INSN;
            w_stall      <= STALL_BRANCH;
            w_regfile_we <= 1'b0;
            w_nzp_we     <= 1'b0;
            w_is_load    <= 1'b0;
        end else begin
            w_insn       <= m_insn;
            w_stall      <= m_stall;
            w_regfile_we <= m_regfile_we;
            w_nzp_we     <= m_nzp_we;
            w_is_load    <= m_is_load;
        end
    end

    always_ff @(posedge gwe) begin
        w_pc        <= m_pc;
        w_result    <= m_result;
        w_load_data <= i_cur_dmem_data;
        w_nzp       <= m_is_load ? load_nzp : m_nzp;
        w_rd_sel    <= m_rd_sel;
    end

    assign wb_data = w_is_load ? w_load_data : w_result;

    assign o_cur_pc            = f_pc;
    assign o_test_stall        = w_stall;
    assign o_test_cur_pc       = w_pc;
    assign o_test_cur_insn     = w_insn;
    assign o_test_regfile_data = wb_data;
    assign o_test_regfile_we   = w_regfile_we;
    assign o_test_regfile_wsel = w_rd_sel;
    assign o_test_nzp_we       = w_nzp_we;
    assign o_test_nzp_new_bits = w_nzp;

endmodule

`default_nettype wire

// ==== sim/lc4_processor_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_processor_props
    import lc4_pkg::*;
(
    input logic   gwe,
    input logic   i_rst,
    input logic   i_dmem_we,
    input stall_t i_test_stall,
    input logic   i_test_regfile_we,
    input logic   i_test_nzp_we,
    input nzp_t   i_test_nzp_new_bits
);

    int unsigned assert_fails = 0;

    // no store leaves the core during reset or the cycle after
    dmem_quiet_in_reset: assert property (@(posedge gwe) i_rst |=> !i_dmem_we)
        else begin
            $error("data memory write enable high around reset");
            assert_fails++;
        end

    // bubbles write nothing
    bubble_no_writes: assert property (@(posedge gwe) disable iff (i_rst)
        (i_test_stall != STALL_NONE) |-> (!i_test_regfile_we && !i_test_nzp_we))
        else begin
            $error("stall record carries a register or nzp write");
            assert_fails++;
        end

    nzp_one_hot: assert property (@(posedge gwe) disable iff (i_rst)
        i_test_nzp_we |-> $onehot(i_test_nzp_new_bits))
        else begin
            $error("nzp bits not one-hot on an nzp write");
            assert_fails++;
        end

endmodule

bind lc4_processor lc4_processor_props u_props (
    .gwe(gwe), .i_rst(i_rst), .i_dmem_we(o_dmem_we), .i_test_stall(o_test_stall),
    .i_test_regfile_we(o_test_regfile_we), .i_test_nzp_we(o_test_nzp_we),
    .i_test_nzp_new_bits(o_test_nzp_new_bits)
);

`default_nettype wire

// ==== sim/tb_lc4_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_processor
    import lc4_pkg::*;
();

    localparam int IMEM_DEPTH = 32;
    localparam int DMEM_DEPTH = 256;
    localparam int PROG_LEN   = 24;
    localparam int WAIT_LIMIT = 20;

    localparam nzp_t NZP_N = 3'b100;
    localparam nzp_t NZP_Z = 3'b010;
    localparam nzp_t NZP_P = 3'b001;

    // one retirement seen at the trace ports plus the bubbles ahead of it
    typedef struct packed {
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_sel_t wsel;
        word_t    data;
        nzp_t     nzp;
        stall_t   pre_stall;
        int       pre_count;
    } retire_t;

    logic     gwe;
    logic     rst;
    word_t    cur_pc;
    word_t    cur_insn;
    word_t    dmem_addr;
    logic     dmem_we;
    word_t    dmem_towrite;
    word_t    dmem_rdata;
    stall_t   test_stall;
    word_t    test_pc;
    word_t    test_insn;
    word_t    test_data;
    logic     test_we;
    reg_sel_t test_wsel;
    logic     test_nzp_we;
    nzp_t     test_nzp_bits;

    word_t    imem [IMEM_DEPTH];
    word_t    dmem [DMEM_DEPTH];
    word_t    imem_idx;
    retire_t  exp_trace [$];

    word_t prog_table [PROG_LEN] = '{
        16'h9205,   // CONST R1, #5
        16'h95FD,   // CONST R2, #-3
        16'h1642,   // ADD R3, R1, R2
        16'h18C9,   // MUL R4, R3, R1
        16'h1AD4,   // SUB R5, R3, R4
        16'h5D5A,   // XOR R6, R5, R2
        16'h5F85,   // AND R7, R6, R5
        16'h53D4,   // OR R1, R7, R4
        16'h5448,   // NOT R2, R1
        16'h16A7,   // ADD R3, R2, #7
        16'h9A10,   // CONST R5, #16
        16'h58E6,   // AND R4, R3, #6
        16'h7942,   // STR R4, R5, #2
        16'h6D42,   // LDR R6, R5, #2
        16'h1F86,   // ADD R7, R6, R6
        16'h637F,   // LDR R1, R5, #-1
        16'h7343,   // STR R1, R5, #3
        16'h6543,   // LDR R2, R5, #3
        16'h0405,   // BRz #5 (not taken)
        16'h0802,   // BRn #2 (taken)
        16'h9601,   // CONST R3, #1 (skipped)
        16'h9602,   // CONST R3, #2 (skipped)
        16'h17F8,   // ADD R3, R7, #-8
        16'h0FFF    // BRnzp #-1
    };

    lc4_processor dut0 (
        .gwe(gwe), .i_rst(rst), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
        .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_towrite(dmem_towrite),
        .i_cur_dmem_data(dmem_rdata), .o_test_stall(test_stall),
        .o_test_cur_pc(test_pc), .o_test_cur_insn(test_insn),
        .o_test_regfile_data(test_data), .o_test_regfile_we(test_we),
        .o_test_regfile_wsel(test_wsel), .o_test_nzp_we(test_nzp_we),
        .o_test_nzp_new_bits(test_nzp_bits)
    );

    initial gwe = 1'b0;
    always #20 gwe = ~gwe;

    // contents of data words never stored depend on every address bit
    function automatic word_t fill_word(input word_t addr);
        return ~addr ^ 16'h1234;
    endfunction

    // both memories answer combinationally and data writes land on the edge
    assign imem_idx   = cur_pc - PC_RESET;
    assign cur_insn   = (imem_idx < IMEM_DEPTH) ? imem[imem_idx[4:0]] : NOP_INSN;
    assign dmem_rdata = (dmem_addr < DMEM_DEPTH) ? dmem[dmem_addr[7:0]] : fill_word(dmem_addr);

    always @(posedge gwe) begin
        if (dmem_we && (dmem_addr < DMEM_DEPTH)) begin
            dmem[dmem_addr[7:0]] <= dmem_towrite;
        end
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_sel(input reg_sel_t actual, input reg_sel_t expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is R%0d, expected R%0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_nzp(input nzp_t actual, input nzp_t expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_stall(input stall_t actual, input stall_t expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic add_expected(input word_t pc, input word_t insn, input logic rf_we,
                                input reg_sel_t wsel, input word_t data, input nzp_t nzp,
                                input stall_t pre_stall, input int pre_count);
        retire_t rec;
        rec = '{pc, insn, rf_we, wsel, data, nzp, pre_stall, pre_count};
        exp_trace.push_back(rec);
    endtask

    // worked out by hand from the ISA and the pipeline timing
    task automatic load_expected();
        add_expected(16'h8200, 16'h9205, 1'b1, 3'd1, 16'h0005, NZP_P, STALL_BRANCH, 3);
        add_expected(16'h8201, 16'h95FD, 1'b1, 3'd2, 16'hFFFD, NZP_N, STALL_NONE, 0);
        add_expected(16'h8202, 16'h1642, 1'b1, 3'd3, 16'h0002, NZP_P, STALL_NONE, 0);
        add_expected(16'h8203, 16'h18C9, 1'b1, 3'd4, 16'h000A, NZP_P, STALL_NONE, 0);
        add_expected(16'h8204, 16'h1AD4, 1'b1, 3'd5, 16'hFFF8, NZP_N, STALL_NONE, 0);
        add_expected(16'h8205, 16'h5D5A, 1'b1, 3'd6, 16'h0005, NZP_P, STALL_NONE, 0);
        add_expected(16'h8206, 16'h5F85, 1'b1, 3'd7, 16'h0000, NZP_Z, STALL_NONE, 0);
        add_expected(16'h8207, 16'h53D4, 1'b1, 3'd1, 16'h000A, NZP_P, STALL_NONE, 0);
        add_expected(16'h8208, 16'h5448, 1'b1, 3'd2, 16'hFFF5, NZP_N, STALL_NONE, 0);
        add_expected(16'h8209, 16'h16A7, 1'b1, 3'd3, 16'hFFFC, NZP_N, STALL_NONE, 0);
        add_expected(16'h820A, 16'h9A10, 1'b1, 3'd5, 16'h0010, NZP_P, STALL_NONE, 0);
        add_expected(16'h820B, 16'h58E6, 1'b1, 3'd4, 16'h0004, NZP_P, STALL_NONE, 0);
        add_expected(16'h820C, 16'h7942, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE, 0);
        add_expected(16'h820D, 16'h6D42, 1'b1, 3'd6, 16'h0004, NZP_P, STALL_NONE, 0);
        add_expected(16'h820E, 16'h1F86, 1'b1, 3'd7, 16'h0008, NZP_P, STALL_LOAD, 1);
        add_expected(16'h820F, 16'h637F, 1'b1, 3'd1, 16'hEDC4, NZP_N, STALL_NONE, 0);
        add_expected(16'h8210, 16'h7343, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE, 0);
        add_expected(16'h8211, 16'h6543, 1'b1, 3'd2, 16'hEDC4, NZP_N, STALL_NONE, 0);
        add_expected(16'h8212, 16'h0405, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE, 0);
        add_expected(16'h8213, 16'h0802, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE, 0);
        add_expected(16'h8216, 16'h17F8, 1'b1, 3'd3, 16'h0000, NZP_Z, STALL_BRANCH, 2);
        add_expected(16'h8217, 16'h0FFF, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE, 0);
        add_expected(16'h8217, 16'h0FFF, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_BRANCH, 2);
    endtask

    // bubbles are checked one by one until the next real retirement
    task automatic await_record(input int idx);
        retire_t rec;
        int      bubbles;
        rec     = exp_trace[idx];
        bubbles = 0;
        @(negedge gwe);
        while ((test_stall !== STALL_NONE) && (bubbles < WAIT_LIMIT)) begin
            check_stall(test_stall, rec.pre_stall, $sformatf("bubble before record %0d", idx));
            bubbles++;
            @(negedge gwe);
        end
        if (test_stall !== STALL_NONE) begin
            $display("Timeout: record %0d did not retire within %0d cycles", idx, WAIT_LIMIT);
            abort_run();
        end
        check_count(bubbles, rec.pre_count, $sformatf("bubbles before record %0d", idx));
        check_word(test_pc, rec.pc, $sformatf("record %0d pc", idx));
        check_word(test_insn, rec.insn, $sformatf("record %0d insn", idx));
        check_flag(test_we, rec.rf_we, $sformatf("record %0d regfile we", idx));
        check_flag(test_nzp_we, rec.rf_we, $sformatf("record %0d nzp we", idx));
        if (rec.rf_we) begin
            check_sel(test_wsel, rec.wsel, $sformatf("record %0d wsel", idx));
            check_word(test_data, rec.data, $sformatf("record %0d data", idx));
            check_nzp(test_nzp_bits, rec.nzp, $sformatf("record %0d nzp bits", idx));
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            imem[i] = (i < PROG_LEN) ? prog_table[i] : NOP_INSN;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] = fill_word(word_t'(i));
        end
        load_expected();

        repeat (3) @(posedge gwe);
        rst <= 1'b0;
        @(negedge gwe);
        check_word(cur_pc, PC_RESET, "fetch pc after reset");
        check_flag(dmem_we, 1'b0, "data memory we after reset");
        check_stall(test_stall, STALL_BRANCH, "trace stall after reset");

        for (int i = 0; i < exp_trace.size(); i++) begin
            await_record(i);
        end

        // both stores must have landed in the modeled memory
        check_word(dmem[8'h12], 16'h0004, "data memory word 0x0012");
        check_word(dmem[8'h13], 16'hEDC4, "data memory word 0x0013");

        if (dut0.u_props.assert_fails == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", dut0.u_props.assert_fails);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_alu.sv
verilog/lc4_hazard_unit.sv
verilog/lc4_processor.sv
sim/lc4_processor_props.sv
sim/tb_lc4_processor.sv

// ==== Bender.yml ====
package:
  name: lc4_pipeline

sources:
  - files:
      - verilog/lc4_pkg.sv
      - verilog/lc4_decoder.sv
      - verilog/lc4_regfile.sv
      - verilog/lc4_alu.sv
      - verilog/lc4_hazard_unit.sv
      - verilog/lc4_processor.sv
  - target: simulation
    files:
      - sim/lc4_processor_props.sv
      - sim/tb_lc4_processor.sv
